// File: common/dsp_pkg.sv
package dsp_pkg;

    typedef logic [15:0]        word_t;
    typedef logic signed [31:0] prod_t;
    typedef logic signed [35:0] acc_t;

    // Opcode in instruction bits 15:12
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDS  = 4'd1,
        OP_LDL  = 4'd2,
        OP_LDM  = 4'd3,
        OP_STM  = 4'd4,
        OP_MAC  = 4'd5,
        OP_MPY  = 4'd6,
        OP_CLR  = 4'd7,
        OP_DO   = 4'd8,
        OP_GOTO = 4'd9
    } op_e;

    // Register select in bits 11:9
    typedef enum logic [2:0] {
        R0  = 3'd0,
        R1  = 3'd1,
        R2  = 3'd2,
        R3  = 3'd3,
        X   = 3'd4,
        Y   = 3'd5,
        PDX = 3'd6,
        A0H = 3'd7
    } reg_e;

    // Source of the shared register bus
    typedef enum logic [1:0] {
        SRC_RAM = 2'd0,
        SRC_DAU = 2'd1,
        SRC_PIO = 2'd2
    } src_e;

    // Field positions
    localparam int OP_LSB   = 12;
    localparam int REG_LSB  = 9;
    localparam int PTR_LSB  = 0;
    localparam int INC_BIT  = 2;
    // LDM/STM with this bit set go to the parallel port instead of RAM
    localparam int IO_BIT   = 8;
    localparam int CNT_W    = 7;
    localparam int GOTO_W   = 12;

    // Bits of the immediate load strobe
    localparam int IMM_SHORT = 0;
    localparam int IMM_LONG  = 1;

    localparam int ROM_AW_DEF = 12;
    localparam int RAM_AW_DEF = 10;

    function automatic word_t sext_short(input logic [8:0] imm);
        return {{7{imm[8]}}, imm};
    endfunction

endpackage

// File: ctrl/dsp_ctrl.sv
`timescale 1ns/1ps

module dsp_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clk_en,
    input  dsp_pkg::word_t         rom_dout,
    output logic                   cen,
    output dsp_pkg::word_t         long_imm,
    output logic [8:0]             short_imm,
    output dsp_pkg::reg_e          reg_field,
    output logic [1:0]             ptr_sel,
    output logic                   post_inc,
    output dsp_pkg::src_e          src_sel,
    output logic                   ram_load,
    output logic                   ram_we,
    output logic [1:0]             imm_load,
    output logic                   dau_load,
    output logic                   mac_en,
    output logic                   mpy_en,
    output logic                   acc_clr,
    output logic                   pdx_write,
    output logic                   pdx_read,
    output logic                   goto_en,
    output logic [11:0]            goto_addr,
    output logic                   long_skip,
    output logic                   pc_hold,
    output logic                   fault
);
    import dsp_pkg::*;

    logic             div;
    logic             skip;
    logic             ldl_pend;
    logic             in_pend;
    reg_e             pend_reg;
    logic [CNT_W-1:0] rep_cnt;
    logic [CNT_W-1:0] do_cnt;
    logic [3:0]       opcode;
    logic             exec;
    logic             io;
    logic             is_lds, is_ldl, is_ldm, is_stm, is_do, illegal;

    // Core runs at half the input enable rate
    always_ff @(posedge clk) begin
        if (reset)
            div <= 1'b0;
        else if (clk_en)
            div <= ~div;
    end
    assign cen = clk_en & div;

    // Fetched word is an instruction unless it is a bubble or an operand
    assign exec   = ~skip & ~ldl_pend & ~in_pend;
    assign opcode = rom_dout[OP_LSB +: 4];
    assign io     = rom_dout[IO_BIT];
    assign do_cnt = rom_dout[CNT_W-1:0];

    assign is_lds  = exec && opcode == OP_LDS;
    assign is_ldl  = exec && opcode == OP_LDL;
    assign is_ldm  = exec && opcode == OP_LDM;
    assign is_stm  = exec && opcode == OP_STM;
    assign is_do   = exec && opcode == OP_DO;
    assign illegal = exec && opcode > OP_GOTO;

    assign mac_en  = exec && opcode == OP_MAC;
    assign mpy_en  = exec && opcode == OP_MPY;
    assign acc_clr = exec && opcode == OP_CLR;
    assign goto_en = exec && opcode == OP_GOTO;

    assign long_imm  = rom_dout;
    assign short_imm = rom_dout[8:0];
    assign goto_addr = rom_dout[GOTO_W-1:0];
    assign ptr_sel   = rom_dout[PTR_LSB +: 2];

    // Operand cycles reuse the register of the instruction that started them
    assign reg_field = (ldl_pend | in_pend) ? pend_reg : reg_e'(rom_dout[REG_LSB +: 3]);

    assign ram_load  = is_ldm & ~io;
    assign ram_we    = is_stm & ~io;
    assign pdx_read  = is_ldm & io;
    assign pdx_write = is_stm & io;
    assign post_inc  = (ram_load | ram_we) & rom_dout[INC_BIT];
    assign dau_load  = in_pend;
    assign long_skip = ldl_pend;

    always_comb begin
        imm_load            = '0;
        imm_load[IMM_SHORT] = is_lds;
        imm_load[IMM_LONG]  = ldl_pend;
    end

    always_comb begin
        if (in_pend)
            src_sel = SRC_PIO;
        else if (reg_field == PDX)
            src_sel = SRC_PIO;
        else if (reg_field[2])
            src_sel = SRC_DAU;
        else
            src_sel = SRC_RAM;
    end

    // Hold the fetch on the repeated word, and once for a port read
    assign pc_hold = (is_do && do_cnt > 7'd1) || rep_cnt > 7'd1 || pdx_read;

    always_ff @(posedge clk) begin
        if (reset) begin
            skip     <= 1'b1;
            ldl_pend <= 1'b0;
            in_pend  <= 1'b0;
            pend_reg <= R0;
            rep_cnt  <= '0;
            fault    <= 1'b0;
        end else if (cen) begin
            skip     <= goto_en;
            ldl_pend <= is_ldl;
            in_pend  <= pdx_read;
            if (exec)
                pend_reg <= reg_e'(rom_dout[REG_LSB +: 3]);
            if (is_do)
                rep_cnt <= (do_cnt == '0) ? '0 : do_cnt - 7'd1;
            else if (rep_cnt != '0)
                rep_cnt <= rep_cnt - 7'd1;
            if (illegal)
                fault <= 1'b1;
        end
    end

endmodule

// File: rom/dsp_rom.sv
`timescale 1ns/1ps

module dsp_rom #(
    parameter int ROM_AW = dsp_pkg::ROM_AW_DEF
) (
    input  logic              clk,
    input  logic              cen,
    input  logic [ROM_AW-1:0] addr,
    input  logic [ROM_AW:0]   prog_addr,
    input  logic [7:0]        prog_data,
    input  logic              prog_we,
    output dsp_pkg::word_t    dout
);
    import dsp_pkg::*;

    word_t mem [2**ROM_AW];

    // Byte writes, odd address is the high byte
    always_ff @(posedge clk) begin
        if (prog_we) begin
            if (prog_addr[0])
                mem[prog_addr[ROM_AW:1]][15:8] <= prog_data;
            else
                mem[prog_addr[ROM_AW:1]][7:0] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (cen)
            dout <= mem[addr];
    end

endmodule

// File: rom/dsp_rom_aau.sv
`timescale 1ns/1ps

module dsp_rom_aau #(
    parameter int ROM_AW = dsp_pkg::ROM_AW_DEF
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic              goto_en,
    input  logic [11:0]       goto_addr,
    input  logic              long_skip,
    input  logic              pc_hold,
    output logic [ROM_AW-1:0] rom_addr
);

    logic [ROM_AW-1:0] pc;

    // PC points at the word being fetched, one ahead of the decoder.
    // An operand word always moves on, even inside a repeat.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (cen) begin
            if (goto_en)
                pc <= ROM_AW'(goto_addr);
            else if (!pc_hold || long_skip)
                pc <= pc + 1'b1;
        end
    end

    assign rom_addr = pc;

endmodule

// File: ram/dsp_ram_aau.sv
`timescale 1ns/1ps

module dsp_ram_aau #(
    parameter int RAM_AW = dsp_pkg::RAM_AW_DEF
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           cen,
    input  dsp_pkg::reg_e  reg_field,
    input  logic [1:0]     ptr_sel,
    input  logic           post_inc,
    input  logic [1:0]     imm_load,
    input  logic           ram_load,
    input  logic           ram_we,
    input  logic [8:0]     short_imm,
    input  dsp_pkg::word_t long_imm,
    input  dsp_pkg::word_t rmux,
    output dsp_pkg::word_t ram_dout,
    output dsp_pkg::word_t r_ram
);
    import dsp_pkg::*;

    word_t             ptr [4];
    word_t             mem [2**RAM_AW];
    word_t             load_val;
    logic [RAM_AW-1:0] ram_addr;
    logic              ptr_load;

    assign ram_addr = ptr[ptr_sel][RAM_AW-1:0];
    assign ram_dout = mem[ram_addr];

    always_comb begin
        if (imm_load[IMM_LONG])
            load_val = long_imm;
        else if (imm_load[IMM_SHORT])
            load_val = sext_short(short_imm);
        else
            load_val = ram_dout;
    end

    // Only r0 to r3 live here
    assign ptr_load = (|imm_load || ram_load) && !reg_field[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++)
                ptr[i] <= '0;
        end else if (cen) begin
            if (post_inc)
                ptr[ptr_sel] <= ptr[ptr_sel] + 16'd1;
            // Load wins over the increment of the same pointer
            if (ptr_load)
                ptr[reg_field[1:0]] <= load_val;
        end
    end

    always_ff @(posedge clk) begin
        if (cen && ram_we)
            mem[ram_addr] <= rmux;
    end

    assign r_ram = ptr[reg_field[1:0]];

endmodule

// File: dau/dsp_dau.sv
`timescale 1ns/1ps

module dsp_dau (
    input  logic           clk,
    input  logic           reset,
    input  logic           cen,
    input  dsp_pkg::reg_e  reg_field,
    input  logic [1:0]     imm_load,
    input  logic           ram_load,
    input  logic           dau_load,
    input  logic           mac_en,
    input  logic           mpy_en,
    input  logic           acc_clr,
    input  logic [8:0]     short_imm,
    input  dsp_pkg::word_t long_imm,
    input  dsp_pkg::word_t ram_dout,
    input  dsp_pkg::word_t rmux,
    output dsp_pkg::word_t r_dau
);
    import dsp_pkg::*;

    word_t x;
    word_t y;
    acc_t  a0;
    prod_t prod;
    word_t load_val;
    logic  any_load;

    assign prod = $signed(x) * $signed(y);

    always_comb begin
        if (imm_load[IMM_LONG])
            load_val = long_imm;
        else if (imm_load[IMM_SHORT])
            load_val = sext_short(short_imm);
        else if (ram_load)
            load_val = ram_dout;
        else
            load_val = rmux;
    end

    assign any_load = |imm_load || ram_load || dau_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            x  <= '0;
            y  <= '0;
            a0 <= '0;
        end else if (cen) begin
            if (acc_clr)
                a0 <= '0;
            else if (mpy_en)
                a0 <= {{4{prod[31]}}, prod};
            else if (mac_en)
                a0 <= a0 + {{4{prod[31]}}, prod};
            if (any_load) begin
                case (reg_field)
                    X:       x <= load_val;
                    Y:       y <= load_val;
                    // Loaded word lands in bits 31:16
                    A0H:     a0 <= {{4{load_val[15]}}, load_val, 16'h0000};
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_field)
            Y:       r_dau = y;
            A0H:     r_dau = a0[31:16];
            default: r_dau = x;
        endcase
    end

endmodule

// File: src/dsp_pio.sv
`timescale 1ns/1ps

module dsp_pio (
    input  logic           clk,
    input  logic           reset,
    input  logic           cen,
    input  logic           pdx_write,
    input  logic           pdx_read,
    input  dsp_pkg::word_t rmux,
    input  dsp_pkg::word_t pbus_in,
    output dsp_pkg::word_t pbus_out,
    output logic           pods_n,
    output logic           pids_n,
    output dsp_pkg::word_t pio_dout
);
    import dsp_pkg::*;

    word_t in_latch;

    // Strobes last one cen period
    always_ff @(posedge clk) begin
        if (reset) begin
            pbus_out <= '0;
            pods_n   <= 1'b1;
            pids_n   <= 1'b1;
        end else if (cen) begin
            pods_n <= ~pdx_write;
            pids_n <= ~pdx_read;
            if (pdx_write)
                pbus_out <= rmux;
        end
    end

    // Sampled at the end of the input strobe
    always_ff @(posedge clk) begin
        if (cen && !pids_n)
            in_latch <= pbus_in;
    end

    // Forward the bus during the strobe so the load can happen on its last edge
    assign pio_dout = pids_n ? in_latch : pbus_in;

endmodule

// File: src/dsp_core.sv
`timescale 1ns/1ps

module dsp_core #(
    parameter int ROM_AW = dsp_pkg::ROM_AW_DEF,
    parameter int RAM_AW = dsp_pkg::RAM_AW_DEF
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           clk_en,
    input  logic [ROM_AW:0] prog_addr,
    input  logic [7:0]     prog_data,
    input  logic           prog_we,
    input  dsp_pkg::word_t pbus_in,
    output logic           cen_cko,
    output dsp_pkg::word_t pbus_out,
    output logic           pods_n,
    output logic           pids_n,
    output logic           fault
);
    import dsp_pkg::*;

    logic              cen;
    word_t             rom_dout;
    logic [ROM_AW-1:0] rom_addr;
    word_t             long_imm;
    logic [8:0]        short_imm;
    reg_e              reg_field;
    logic [1:0]        ptr_sel;
    logic              post_inc;
    src_e              src_sel;
    logic              ram_load, ram_we, dau_load;
    logic [1:0]        imm_load;
    logic              mac_en, mpy_en, acc_clr;
    logic              pdx_write, pdx_read;
    logic              goto_en, long_skip, pc_hold;
    logic [11:0]       goto_addr;
    word_t             ram_dout, r_ram, r_dau, pio_dout, rmux;

    assign cen_cko = cen;

    // Shared source bus
    always_comb begin
        case (src_sel)
            SRC_RAM: rmux = r_ram;
            SRC_DAU: rmux = r_dau;
            default: rmux = pio_dout;
        endcase
    end

    dsp_ctrl u_ctrl (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .clk_en    ( clk_en    ),
        .rom_dout  ( rom_dout  ),
        .cen       ( cen       ),
        .long_imm  ( long_imm  ),
        .short_imm ( short_imm ),
        .reg_field ( reg_field ),
        .ptr_sel   ( ptr_sel   ),
        .post_inc  ( post_inc  ),
        .src_sel   ( src_sel   ),
        .ram_load  ( ram_load  ),
        .ram_we    ( ram_we    ),
        .imm_load  ( imm_load  ),
        .dau_load  ( dau_load  ),
        .mac_en    ( mac_en    ),
        .mpy_en    ( mpy_en    ),
        .acc_clr   ( acc_clr   ),
        .pdx_write ( pdx_write ),
        .pdx_read  ( pdx_read  ),
        .goto_en   ( goto_en   ),
        .goto_addr ( goto_addr ),
        .long_skip ( long_skip ),
        .pc_hold   ( pc_hold   ),
        .fault     ( fault     )
    );

    dsp_rom #(.ROM_AW(ROM_AW)) u_rom (
        .clk       ( clk       ),
        .cen       ( cen       ),
        .addr      ( rom_addr  ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .dout      ( rom_dout  )
    );

    dsp_rom_aau #(.ROM_AW(ROM_AW)) u_rom_aau (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .goto_en   ( goto_en   ),
        .goto_addr ( goto_addr ),
        .long_skip ( long_skip ),
        .pc_hold   ( pc_hold   ),
        .rom_addr  ( rom_addr  )
    );

    dsp_ram_aau #(.RAM_AW(RAM_AW)) u_ram_aau (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .reg_field ( reg_field ),
        .ptr_sel   ( ptr_sel   ),
        .post_inc  ( post_inc  ),
        .imm_load  ( imm_load  ),
        .ram_load  ( ram_load  ),
        .ram_we    ( ram_we    ),
        .short_imm ( short_imm ),
        .long_imm  ( long_imm  ),
        .rmux      ( rmux      ),
        .ram_dout  ( ram_dout  ),
        .r_ram     ( r_ram     )
    );

    dsp_dau u_dau (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .reg_field ( reg_field ),
        .imm_load  ( imm_load  ),
        .ram_load  ( ram_load  ),
        .dau_load  ( dau_load  ),
        .mac_en    ( mac_en    ),
        .mpy_en    ( mpy_en    ),
        .acc_clr   ( acc_clr   ),
        .short_imm ( short_imm ),
        .long_imm  ( long_imm  ),
        .ram_dout  ( ram_dout  ),
        .rmux      ( rmux      ),
        .r_dau     ( r_dau     )
    );

    dsp_pio u_pio (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .pdx_write ( pdx_write ),
        .pdx_read  ( pdx_read  ),
        .rmux      ( rmux      ),
        .pbus_in   ( pbus_in   ),
        .pbus_out  ( pbus_out  ),
        .pods_n    ( pods_n    ),
        .pids_n    ( pids_n    ),
        .pio_dout  ( pio_dout  )
    );

endmodule

// File: verif/dsp_clk_gen.sv
`timescale 1ns/1ps

module dsp_clk_gen #(
    parameter int RESET_CYCLES = 10
) (
    input  logic hold,
    output logic clk,
    output logic reset
);

    int rst_cnt = RESET_CYCLES;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Reset stays high while held, then for RESET_CYCLES more
    always @(posedge clk) begin
        if (hold)
            rst_cnt <= RESET_CYCLES;
        else if (rst_cnt != 0)
            rst_cnt <= rst_cnt - 1;
    end

    assign reset = (rst_cnt != 0);

endmodule

// File: verif/dsp_core_tb.sv
`timescale 1ns/1ps

module dsp_core_tb;
    import dsp_pkg::*;

    localparam int ROM_AW         = 12;
    localparam int RAM_AW         = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_ROWS       = 6;
    localparam int MAX_WORDS      = 32;
    localparam int TAIL_CYCLES    = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (MAX_WORDS * 4 + RESET_CYCLES + 40);

    // Row kinds
    localparam int K_DOT = 0;
    localparam int K_RAM = 1;
    localparam int K_PIN = 2;
    localparam int K_REP = 3;
    localparam int K_ILL = 4;

    typedef logic [ROM_AW:0] paddr_t;

    // Arg column is the DO count, the RAM base or the illegal word
    // Val columns are port inputs (PIN) or a 9-bit immediate in column 0
    int    row_kind [NUM_ROWS]    = '{K_DOT, K_RAM, K_PIN, K_REP, K_ILL, K_REP};
    word_t row_arg  [NUM_ROWS]    = '{16'h0000, 16'h0040, 16'h0000,
                                      16'h0005, 16'hb123, 16'h0001};
    word_t row_val  [NUM_ROWS][2] = '{
        '{16'h0000, 16'h0000},
        '{16'h0000, 16'h0000},
        '{16'h7ff3, 16'h8a01},
        '{16'h00fb, 16'h0000},
        '{16'h01fb, 16'h0000},
        '{16'h0100, 16'h0000}
    };

    logic        clk;
    logic        reset;
    logic        hold;
    logic        clk_en;
    paddr_t      prog_addr;
    logic [7:0]  prog_data;
    logic        prog_we;
    word_t       pbus_in;
    logic        cen_cko;
    word_t       pbus_out;
    logic        pods_n;
    logic        pids_n;
    logic        fault;

    word_t       prog [$];
    word_t       exp_q [$];
    word_t       in_q [$];
    logic        exp_fault;
    logic [31:0] rng_state = 32'hbd90932f;
    int          cycle_cnt = 0;
    int          err_count = 0;

    dsp_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .hold  ( hold  ),
        .clk   ( clk   ),
        .reset ( reset )
    );

    dsp_core #(.ROM_AW(ROM_AW), .RAM_AW(RAM_AW)) dsp_core_i (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .clk_en    ( clk_en    ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .pbus_in   ( pbus_in   ),
        .cen_cko   ( cen_cko   ),
        .pbus_out  ( pbus_out  ),
        .pods_n    ( pods_n    ),
        .pids_n    ( pids_n    ),
        .fault     ( fault     )
    );

    function automatic word_t xorshift_word();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s[31:16];
    endfunction

    // Assembler helpers
    function automatic word_t encode(op_e op, reg_e r, logic [8:0] low);
        return {op, r, low};
    endfunction

    function automatic word_t encode_mem(op_e op, reg_e r, logic io, logic inc,
                                         logic [1:0] ptr);
        return encode(op, r, {io, 5'b00000, inc, ptr});
    endfunction

    function automatic word_t encode_goto(int addr);
        return {OP_GOTO, addr[11:0]};
    endfunction

    function automatic longint signed_product(word_t a, word_t b);
        return longint'($signed(a)) * longint'($signed(b));
    endfunction

    function automatic word_t high_word(longint v);
        return v[31:16];
    endfunction

    // Value of a 9-bit two's complement immediate as a data word
    function automatic word_t short_imm_value(logic [8:0] imm);
        int v;
        v = imm;
        if (imm[8])
            v = v - 512;
        return word_t'(v);
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_count++;
            stop_with_failure($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            stop_with_failure($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic build_program(input int row);
        word_t      a [4];
        word_t      b [4];
        longint     acc;
        logic [8:0] imm;
        int         i;
        prog.delete();
        exp_q.delete();
        in_q.delete();
        imm       = row_val[row][0][8:0];
        exp_fault = (row_kind[row] == K_ILL);
        acc       = 0;
        case (row_kind[row])
            K_DOT: begin
                prog.push_back(encode(OP_CLR, R0, 9'h000));
                for (i = 0; i < 4; i++) begin
                    a[i] = xorshift_word();
                    b[i] = xorshift_word();
                    prog.push_back(encode(OP_LDL, X, 9'h000));
                    prog.push_back(a[i]);
                    prog.push_back(encode(OP_LDL, Y, 9'h000));
                    prog.push_back(b[i]);
                    prog.push_back(encode(OP_MAC, R0, 9'h000));
                    acc += signed_product(a[i], b[i]);
                end
                prog.push_back(encode_mem(OP_STM, A0H, 1'b1, 1'b0, 2'd0));
                exp_q.push_back(high_word(acc));
            end
            K_RAM: begin
                prog.push_back(encode(OP_LDS, R0, row_arg[row][8:0]));
                prog.push_back(encode(OP_LDS, R1, row_arg[row][8:0]));
                for (i = 0; i < 4; i++) begin
                    a[i] = xorshift_word();
                    prog.push_back(encode(OP_LDL, X, 9'h000));
                    prog.push_back(a[i]);
                    prog.push_back(encode_mem(OP_STM, X, 1'b0, 1'b1, 2'd0));
                end
                // Read back through r1 from the same base
                for (i = 0; i < 4; i++) begin
                    prog.push_back(encode_mem(OP_LDM, Y, 1'b0, 1'b1, 2'd1));
                    prog.push_back(encode_mem(OP_STM, Y, 1'b1, 1'b0, 2'd0));
                    exp_q.push_back(a[i]);
                end
            end
            K_PIN: begin
                prog.push_back(encode_mem(OP_LDM, X, 1'b1, 1'b0, 2'd0));
                prog.push_back(encode_mem(OP_LDM, Y, 1'b1, 1'b0, 2'd0));
                prog.push_back(encode(OP_MPY, R0, 9'h000));
                prog.push_back(encode_mem(OP_STM, A0H, 1'b1, 1'b0, 2'd0));
                in_q.push_back(row_val[row][0]);
                in_q.push_back(row_val[row][1]);
                exp_q.push_back(high_word(signed_product(row_val[row][0], row_val[row][1])));
            end
            K_REP: begin
                a[0] = xorshift_word();
                b[0] = xorshift_word();
                prog.push_back(encode(OP_LDL, X, 9'h000));
                prog.push_back(a[0]);
                prog.push_back(encode(OP_LDL, Y, 9'h000));
                prog.push_back(b[0]);
                prog.push_back(encode(OP_CLR, R0, 9'h000));
                prog.push_back(encode(OP_DO, R0, {2'b00, row_arg[row][6:0]}));
                prog.push_back(encode(OP_MAC, R0, 9'h000));
                prog.push_back(encode_mem(OP_STM, A0H, 1'b1, 1'b0, 2'd0));
                prog.push_back(encode(OP_LDS, X, imm));
                prog.push_back(encode_mem(OP_STM, X, 1'b1, 1'b0, 2'd0));
                acc = longint'(row_arg[row][6:0]) * signed_product(a[0], b[0]);
                exp_q.push_back(high_word(acc));
                exp_q.push_back(short_imm_value(imm));
            end
            default: begin
                prog.push_back(encode(OP_LDS, X, imm));
                prog.push_back(row_arg[row]);
                prog.push_back(encode_mem(OP_STM, X, 1'b1, 1'b0, 2'd0));
                exp_q.push_back(short_imm_value(imm));
            end
        endcase
        prog.push_back(encode_goto(prog.size()));
    endtask

    // Bytes go in while the core sits in reset
    task automatic load_program();
        int i;
        @(posedge clk);
        hold <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        for (i = 0; i < prog.size(); i++) begin
            prog_we   <= 1'b1;
            prog_addr <= paddr_t'(2 * i);
            prog_data <= prog[i][7:0];
            @(posedge clk);
            prog_addr <= paddr_t'(2 * i + 1);
            prog_data <= prog[i][15:8];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        pbus_in <= '0;
        hold    <= 1'b0;
    endtask

    task automatic run_row(input int row);
        int   out_idx;
        int   in_idx;
        int   i;
        logic pods_prev;
        logic pids_prev;
        logic last_cen;
        logic send_in;
        build_program(row);
        if (prog.size() > MAX_WORDS)
            stop_with_failure("program is longer than the timeout budget allows");
        load_program();
        @(negedge clk);
        while (reset)
            @(negedge clk);
        // Idle state right out of reset
        check_flag("pods_n", pods_n, 1'b1);
        check_flag("pids_n", pids_n, 1'b1);
        check_flag("fault", fault, 1'b0);
        last_cen = cen_cko;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            check_flag("cen_cko", cen_cko, ~last_cen);
            last_cen = cen_cko;
        end
        out_idx   = 0;
        in_idx    = 0;
        pods_prev = pods_n;
        pids_prev = pids_n;
        while (out_idx < exp_q.size()) begin
            @(negedge clk);
            if (!pods_n && pods_prev) begin
                check_word("pbus_out", pbus_out, exp_q[out_idx]);
                check_flag("fault", fault, exp_fault);
                out_idx++;
            end
            pods_prev = pods_n;
            send_in   = !pids_n && pids_prev;
            pids_prev = pids_n;
            @(posedge clk);
            // Present the next input once the read strobe is seen low
            if (send_in) begin
                if (in_idx >= in_q.size()) begin
                    stop_with_failure("input strobe seen with no input value left");
                end else begin
                    pbus_in <= in_q[in_idx];
                    in_idx++;
                end
            end
        end
        for (i = 0; i < TAIL_CYCLES; i++) begin
            @(negedge clk);
            if (!pods_n && pods_prev)
                stop_with_failure("output strobe seen after the last expected result");
            pods_prev = pods_n;
        end
        if (in_idx != in_q.size())
            stop_with_failure("program did not read every input value");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_with_failure($sformatf("run timed out after %0d cycles", cycle_cnt));
    end

    initial begin
        int row;
        hold      = 1'b0;
        clk_en    = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        pbus_in   = '0;
        for (row = 0; row < NUM_ROWS; row++)
            run_row(row);
        if (err_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure("one or more checks did not match");
        end
    end

endmodule

// File: dsp16_lite.f
common/dsp_pkg.sv
ctrl/dsp_ctrl.sv
rom/dsp_rom.sv
rom/dsp_rom_aau.sv
ram/dsp_ram_aau.sv
dau/dsp_dau.sv
src/dsp_pio.sv
src/dsp_core.sv
verif/dsp_clk_gen.sv
verif/dsp_core_tb.sv

// File: Bender.yml
package:
  name: dsp16_lite

sources:
  - files:
      - common/dsp_pkg.sv
      - ctrl/dsp_ctrl.sv
      - rom/dsp_rom.sv
      - rom/dsp_rom_aau.sv
      - ram/dsp_ram_aau.sv
      - dau/dsp_dau.sv
      - src/dsp_pio.sv
      - src/dsp_core.sv
  - target: test
    files:
      - verif/dsp_clk_gen.sv
      - verif/dsp_core_tb.sv
